//--- vlog.f
+incdir+.
alu_op_pkg.sv
exe_cfg_pkg.sv
mul_top.sv
divider.sv
alu.sv
exe_unit.sv
tb_exe_unit.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and scan the log for failure
rm -f sim.log \
  && verilator --binary --timing --assert -Wno-fatal -f vlog.f \
       --top-module tb_exe_unit -o sim_exe_unit \
  && ./obj_dir/sim_exe_unit | tee sim.log \
  && ! grep -q "CHECKS FAILED" sim.log \
  || { echo "simulation did not pass"; exit 1; }

//--- tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// expected result of one operation, built from the operation rules
function automatic logic [data_w-1:0] exp_result(input alu_op_e           op,
                                                 input logic [data_w-1:0] a,
                                                 input logic [data_w-1:0] b);
    longint              sa;
    longint              sb;
    logic [2*data_w-1:0] prod_s;
    logic [2*data_w-1:0] prod_u;
    logic                by_zero;
    logic                ovf;
    sa      = {{data_w{a[data_w-1]}}, a};
    sb      = {{data_w{b[data_w-1]}}, b};
    prod_s  = sa * sb;                                        // full signed product
    prod_u  = {{data_w{1'b0}}, a} * {{data_w{1'b0}}, b};
    by_zero = (b == '0);
    ovf     = (a == {1'b1, {(data_w-1){1'b0}}}) && (b == '1); // most negative / -1
    case (op)
        op_add:   return a + b;
        op_sub:   return a - b;
        op_slt:   return {{(data_w-1){1'b0}}, $signed(a) < $signed(b)};
        op_sltu:  return {{(data_w-1){1'b0}}, a < b};
        op_and:   return a & b;
        op_nor:   return ~(a | b);
        op_or:    return a | b;
        op_xor:   return a ^ b;
        op_sll:   return a << b[shamt_w-1:0];
        op_srl:   return a >> b[shamt_w-1:0];
        op_sra:   return $signed(a) >>> b[shamt_w-1:0];
        op_lui:   return b;
        op_mul:   return prod_s[data_w-1:0];
        op_mulh:  return prod_s[2*data_w-1:data_w];
        op_mulhu: return prod_u[2*data_w-1:data_w];
        op_div:   return by_zero ? '1 : (ovf ? a : data_w'(sa / sb));
        op_divu:  return by_zero ? '1 : a / b;
        op_mod:   return by_zero ? a : (ovf ? '0 : data_w'(sa % sb));  // sign of dividend
        op_modu:  return by_zero ? a : a % b;
        default:  return '0;
    endcase
endfunction

`endif

//--- tb_exe_unit.sv
`timescale 1ns/1ps

module tb_exe_unit import alu_op_pkg::*; ();

    localparam int n_directed = 250;  // upper bound on directed operations
    localparam int n_random   = 300;
    localparam int wd_cycles  = (n_directed + n_random) * 40 + 500;

    logic              clk;
    logic              rst;
    logic              in_valid;
    logic              in_ready;
    alu_op_e           in_op;
    logic [data_w-1:0] in_src1;
    logic [data_w-1:0] in_src2;
    logic              out_valid;
    logic              out_ready;
    logic [data_w-1:0] out_result;
    logic              bp_on;       // random back-pressure enable
    logic              bp_next;
    logic              held;        // result seen waiting at last falling edge
    logic [data_w-1:0] held_val;
    logic [data_w-1:0] exp_q[$];
    alu_op_e           op_log[$];

    `include "tb_ref_model.svh"

    exe_unit u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    function automatic logic [data_w-1:0] corner(input int idx);
        case (idx)
            0:       return '0;
            1:       return 32'h0000_0001;
            2:       return 32'h7fff_ffff;
            3:       return 32'h8000_0000;
            default: return '1;
        endcase
    endfunction

    // corner value now and then, otherwise fully random
    function automatic logic [data_w-1:0] pick_operand();
        if ($urandom_range(0, 3) == 0) begin
            return corner($urandom_range(0, 4));
        end
        return $urandom;
    endfunction

    // called just after a rising edge, returns just after the accepting edge
    task automatic issue_op(input alu_op_e op, input logic [data_w-1:0] a,
                            input logic [data_w-1:0] b);
        logic taken;
        in_valid = 1'b1;
        in_op    = op;
        in_src1  = a;
        in_src2  = b;
        taken    = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = in_ready;
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
        exp_q.push_back(exp_result(op, a, b));
        op_log.push_back(op);
    endtask

    // issue with out_ready high and count cycles until out_valid
    task automatic run_timed(input alu_op_e op, input logic [data_w-1:0] a,
                             input logic [data_w-1:0] b, input int latency);
        int cycles;
        issue_op(op, a, b);
        cycles = 0;
        @(negedge clk);
        while (!out_valid && cycles < 100) begin
            cycles++;
            @(negedge clk);
        end
        assert (cycles == latency) else abort_run($sformatf(
            "ERROR out_valid latency for %s: 0x%0h cycles, expected 0x%0h",
            op.name(), cycles, latency));
        @(posedge clk);
        #1;
    endtask

    initial begin
        int sh;
        int guard;
        void'($urandom(38));
        rst      = 1'b1;
        in_valid = 1'b0;
        in_op    = op_add;
        in_src1  = '0;
        in_src2  = '0;
        bp_on    = 1'b0;
        held     = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        assert (in_ready && !out_valid) else abort_run($sformatf(
            "ERROR in_ready/out_valid after reset: 0x%h/0x%h, expected 0x1/0x0",
            in_ready, out_valid));
        @(posedge clk);
        #1;
        for (int op = 0; op < 4; op++) begin        // add, sub, slt, sltu
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    run_timed(alu_op_e'(op), corner(i), corner(j), 1);
                end
            end
        end
        for (int k = 0; k < 4; k++) begin
            for (int op = 4; op < 8; op++) begin    // and, nor, or, xor
                run_timed(alu_op_e'(op), $urandom, $urandom, 1);
            end
            run_timed(op_lui, $urandom, $urandom, 1);
        end
        for (int k = 0; k < 6; k++) begin
            sh = (k == 0) ? 0 : ((k == 1) ? 31 : $urandom_range(1, 30));
            for (int op = 8; op < 11; op++) begin   // upper src2 bits must be ignored
                run_timed(alu_op_e'(op), 32'h8000_0001, {27'($urandom), 5'(sh)}, 1);
                run_timed(alu_op_e'(op), $urandom, {27'($urandom), 5'(sh)}, 1);
            end
        end
        for (int op = 12; op < 15; op++) begin
            for (int i = 1; i < 5; i++) begin
                for (int j = 1; j < 5; j++) begin
                    run_timed(alu_op_e'(op), corner(i), corner(j), 3);
                end
            end
        end
        for (int op = 15; op < 19; op++) begin
            for (int k = 0; k < 6; k++) begin
                issue_op(alu_op_e'(op), $urandom,
                         (k < 3) ? $urandom : 32'($urandom_range(1, 9)));
            end
            issue_op(alu_op_e'(op), $urandom, '0);
            issue_op(alu_op_e'(op), 32'h8000_0000, '1);
            issue_op(alu_op_e'(op), 32'hffff_fff9, 32'h0000_0002);
        end
        bp_on = 1'b1;
        for (int n = 0; n < n_random; n++) begin
            repeat ($urandom_range(0, 2)) begin
                @(posedge clk);
                #1;
            end
            issue_op(alu_op_e'($urandom_range(0, 18)), pick_operand(), pick_operand());
        end
        guard = 0;
        while (exp_q.size() != 0 && guard < 500) begin
            @(posedge clk);
            guard++;
        end
        @(posedge clk);
        if (exp_q.size() == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            abort_run("results still outstanding at the end of the run");
        end
    end

    // out_ready drawn at the falling edge, driven after the rising edge
    initial begin
        out_ready = 1'b1;
        bp_next   = 1'b1;
        forever begin
            @(negedge clk);
            bp_next = bp_on ? 1'($urandom_range(0, 1)) : 1'b1;
            @(posedge clk);
            #1;
            out_ready = bp_next;
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            if (held) begin
                assert (out_valid) else abort_run("out_valid dropped before the result was taken");
                assert (out_result == held_val) else abort_run($sformatf(
                    "ERROR out_result changed while stalled: 0x%08h, held 0x%08h",
                    out_result, held_val));
            end
            held     = out_valid && !out_ready;
            held_val = out_result;
            if (out_valid && out_ready) begin   // handshake at the coming edge
                assert (exp_q.size() != 0) else abort_run("result handed out with nothing issued");
                assert (out_result == exp_q[0]) else abort_run($sformatf(
                    "ERROR out_result for %s: 0x%08h, expected 0x%08h",
                    op_log[0].name(), out_result, exp_q[0]));
                void'(exp_q.pop_front());
                void'(op_log.pop_front());
            end
        end
    end

    initial begin
        repeat (wd_cycles) @(posedge clk);
        abort_run($sformatf("timeout, the run did not end within %0d cycles", wd_cycles));
    end

endmodule

//--- exe_unit.sv
`timescale 1ns/1ps

module exe_unit import alu_op_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    output logic              in_ready,
    input  alu_op_e           in_op,
    input  logic [data_w-1:0] in_src1,
    input  logic [data_w-1:0] in_src2,
    output logic              out_valid,
    input  logic              out_ready,
    output logic [data_w-1:0] out_result
);

    typedef enum logic [1:0] {idle, wait_mul, wait_div} exe_state_e;

    exe_state_e        state;
    logic              issue;      // one cycle after acceptance
    alu_op_e           op_q;
    logic [data_w-1:0] src1_q;
    logic [data_w-1:0] src2_q;
    logic [data_w-1:0] alu_result;
    logic              mul_done;
    logic              div_finish;
    logic              pending;
    logic              accept;
    logic              capture;
    logic              in_is_mul;
    logic              in_is_div;

    assign in_is_mul = in_op inside {op_mul, op_mulh, op_mulhu};
    assign in_is_div = in_op inside {op_div, op_divu, op_mod, op_modu};

    assign pending  = issue || (state != idle);
    assign in_ready = !pending && (!out_valid || out_ready);
    assign accept   = in_valid && in_ready;

    // completion event depends on the class held in state
    assign capture = (issue && state == idle)
                   || (state == wait_mul && mul_done)
                   || (state == wait_div && div_finish);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= idle;
            issue     <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            issue <= accept;
            if (accept) begin
                state <= in_is_mul ? wait_mul : (in_is_div ? wait_div : idle);
            end else if (capture) begin
                state <= idle;
            end
            if (capture) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;           // result taken
            end
        end
    end

    // operation latch
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q   <= in_op;
            src1_q <= in_src1;
            src2_q <= in_src2;
        end
    end

    // output register, held until taken
    always_ff @(posedge clk) begin
        if (capture) begin
            out_result <= alu_result;
        end
    end

    alu u_alu (
        .clk        (clk),
        .rst        (rst),
        .issue      (issue),
        .op         (op_q),
        .src1       (src1_q),
        .src2       (src2_q),
        .result     (alu_result),
        .mul_done   (mul_done),
        .div_finish (div_finish)
    );

endmodule

//--- alu.sv
`timescale 1ns/1ps

module alu import alu_op_pkg::*, exe_cfg_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              issue,
    input  alu_op_e           op,
    input  logic [data_w-1:0] src1,
    input  logic [data_w-1:0] src2,
    output logic [data_w-1:0] result,
    output logic              mul_done,
    output logic              div_finish
);

    logic is_add, is_sub, is_slt, is_sltu;
    logic is_and, is_nor, is_or, is_xor;
    logic is_sll, is_srl, is_sra, is_lui;
    logic is_mul, is_mulh, is_mulhu;
    logic is_div, is_divu, is_mod, is_modu;
    logic use_sub;
    logic mul_any;
    logic div_any;
    logic div_start;
    logic [data_w-1:0]     adder_b;
    logic [data_w-1:0]     adder_sum;
    logic                  adder_cout;
    logic                  slt_bit;
    logic                  sltu_bit;
    logic [shamt_w-1:0]    shamt;
    logic [data_w-1:0]     sll_res;
    logic [2*data_w-1:0]   sr64_res;
    logic [data_w:0]       mul_a;
    logic [data_w:0]       mul_b;
    logic [2*data_w-1:0]   prod;
    logic [mul_stages-1:0] mul_vld_sr;
    logic [mul_stages-1:0] mul_hi_sr;
    logic [data_w-1:0]     mul_word;
    logic [data_w-1:0]     div_q;
    logic [data_w-1:0]     div_r;

    // one-hot decode
    assign is_add   = (op == op_add);
    assign is_sub   = (op == op_sub);
    assign is_slt   = (op == op_slt);
    assign is_sltu  = (op == op_sltu);
    assign is_and   = (op == op_and);
    assign is_nor   = (op == op_nor);
    assign is_or    = (op == op_or);
    assign is_xor   = (op == op_xor);
    assign is_sll   = (op == op_sll);
    assign is_srl   = (op == op_srl);
    assign is_sra   = (op == op_sra);
    assign is_lui   = (op == op_lui);
    assign is_mul   = (op == op_mul);
    assign is_mulh  = (op == op_mulh);
    assign is_mulhu = (op == op_mulhu);
    assign is_div   = (op == op_div);
    assign is_divu  = (op == op_divu);
    assign is_mod   = (op == op_mod);
    assign is_modu  = (op == op_modu);

    assign mul_any   = is_mul | is_mulh | is_mulhu;
    assign div_any   = is_div | is_divu | is_mod | is_modu;
    assign div_start = issue & div_any;  // first cycle only

    // shared adder, subtract as src1 + ~src2 + 1
    assign use_sub = is_sub | is_slt | is_sltu;
    assign adder_b = use_sub ? ~src2 : src2;
    assign {adder_cout, adder_sum} = {1'b0, src1} + {1'b0, adder_b}
                                   + {{data_w{1'b0}}, use_sub};

    assign slt_bit  = (src1[data_w-1] & ~src2[data_w-1])
                    | (~(src1[data_w-1] ^ src2[data_w-1]) & adder_sum[data_w-1]);
    assign sltu_bit = ~adder_cout;  // borrow out

    assign shamt    = src2[shamt_w-1:0];
    assign sll_res  = src1 << shamt;
    assign sr64_res = {{data_w{is_sra & src1[data_w-1]}}, src1} >> shamt;  // sign fill

    // mulhu zero extends, the others sign extend
    assign mul_a = {~is_mulhu & src1[data_w-1], src1};
    assign mul_b = {~is_mulhu & src2[data_w-1], src2};

    mul_top u_mul (
        .clk  (clk),
        .rst  (rst),
        .src1 (mul_a),
        .src2 (mul_b),
        .res  (prod)
    );

    // half select and valid travel beside the multiplier
    always_ff @(posedge clk) begin
        if (rst) begin
            mul_vld_sr <= '0;
            mul_hi_sr  <= '0;
        end else begin
            mul_vld_sr[0] <= issue & mul_any;
            mul_hi_sr[0]  <= is_mulh | is_mulhu;
            for (int i = 1; i < mul_stages; i++) begin
                mul_vld_sr[i] <= mul_vld_sr[i-1];
                mul_hi_sr[i]  <= mul_hi_sr[i-1];
            end
        end
    end

    assign mul_done = mul_vld_sr[mul_stages-1];
    assign mul_word = mul_hi_sr[mul_stages-1] ? prod[2*data_w-1:data_w] : prod[data_w-1:0];

    divider u_div (
        .clk        (clk),
        .rst        (rst),
        .start      (div_start),
        .div_signed (is_div | is_mod),
        .x          (src1),
        .y          (src2),
        .s          (div_q),
        .r          (div_r),
        .complete   (div_finish)
    );

    assign result = ({data_w{is_add | is_sub}}   & adder_sum)
                  | ({data_w{is_slt}}            & {{(data_w-1){1'b0}}, slt_bit})
                  | ({data_w{is_sltu}}           & {{(data_w-1){1'b0}}, sltu_bit})
                  | ({data_w{is_and}}            & (src1 & src2))
                  | ({data_w{is_nor}}            & ~(src1 | src2))
                  | ({data_w{is_or}}             & (src1 | src2))
                  | ({data_w{is_xor}}            & (src1 ^ src2))
                  | ({data_w{is_lui}}            & src2)
                  | ({data_w{is_sll}}            & sll_res)
                  | ({data_w{is_srl | is_sra}}   & sr64_res[data_w-1:0])
                  | ({data_w{mul_any}}           & mul_word)
                  | ({data_w{is_div | is_divu}}  & div_q)
                  | ({data_w{is_mod | is_modu}}  & div_r);

endmodule

//--- divider.sv
`timescale 1ns/1ps

module divider import alu_op_pkg::*, exe_cfg_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic              div_signed,
    input  logic [data_w-1:0] x,
    input  logic [data_w-1:0] y,
    output logic [data_w-1:0] s,
    output logic [data_w-1:0] r,
    output logic              complete
);

    typedef enum logic {idle, run} div_state_e;

    div_state_e           state;
    logic [div_cnt_w-1:0] cnt;
    logic [data_w-1:0]    rem;
    logic [data_w-1:0]    quo;      // dividend shifts out, quotient shifts in
    logic [data_w-1:0]    dvs;
    logic [data_w-1:0]    x_keep;
    logic                 neg_q;
    logic                 neg_r;
    logic                 by_zero;
    logic                 ovf;
    logic                 last;
    logic [data_w-1:0]    abs_x;
    logic [data_w-1:0]    abs_y;
    logic [data_w:0]      shifted;
    logic [data_w+1:0]    diff;
    logic [data_w-1:0]    rem_nxt;
    logic [data_w-1:0]    quo_nxt;
    logic [data_w-1:0]    s_fix;
    logic [data_w-1:0]    r_fix;

    assign abs_x = (div_signed && x[data_w-1]) ? -x : x;
    assign abs_y = (div_signed && y[data_w-1]) ? -y : y;
    assign last  = (cnt == div_cnt_w'(div_iters - 1));

    // one restore step
    assign shifted = {rem, quo[data_w-1]};
    assign diff    = {1'b0, shifted} - {2'b00, dvs};
    assign rem_nxt = diff[data_w+1] ? shifted[data_w-1:0] : diff[data_w-1:0];
    assign quo_nxt = {quo[data_w-2:0], ~diff[data_w+1]};

    always_comb begin
        s_fix = neg_q ? -quo_nxt : quo_nxt;
        r_fix = neg_r ? -rem_nxt : rem_nxt;  // remainder follows dividend sign
        if (by_zero) begin
            s_fix = '1;
            r_fix = x_keep;
        end else if (ovf) begin
            s_fix = x_keep;                  // most negative value stays
            r_fix = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= idle;
            cnt      <= '0;
            complete <= 1'b0;
        end else begin
            complete <= 1'b0;
            case (state)
                idle: begin
                    if (start) begin
                        state <= run;
                        cnt   <= '0;
                    end
                end
                run: begin
                    cnt <= cnt + 1'b1;
                    if (last) begin
                        state    <= idle;
                        complete <= 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && start) begin
            rem     <= '0;
            quo     <= abs_x;
            dvs     <= abs_y;
            x_keep  <= x;
            neg_q   <= div_signed && (x[data_w-1] ^ y[data_w-1]);
            neg_r   <= div_signed && x[data_w-1];
            by_zero <= (y == '0);
            ovf     <= div_signed && (x == {1'b1, {(data_w-1){1'b0}}}) && (y == '1);
        end else if (state == run) begin
            rem <= rem_nxt;
            quo <= quo_nxt;
            if (last) begin
                s <= s_fix;
                r <= r_fix;
            end
        end
    end

endmodule

//--- mul_top.sv
`timescale 1ns/1ps

module mul_top import alu_op_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [data_w:0]       src1,
    input  logic [data_w:0]       src2,
    output logic [2*data_w-1:0]   res
);

    logic signed [data_w/2:0]     a_hi;
    logic signed [data_w/2:0]     a_lo;
    logic signed [data_w/2:0]     b_hi;
    logic signed [data_w/2:0]     b_lo;
    logic signed [data_w+1:0]     pp_hh;
    logic signed [data_w+1:0]     pp_hl;
    logic signed [data_w+1:0]     pp_lh;
    logic signed [data_w+1:0]     pp_ll;
    logic signed [2*data_w-1:0]   ext_hh;
    logic signed [2*data_w-1:0]   ext_hl;
    logic signed [2*data_w-1:0]   ext_lh;
    logic signed [2*data_w-1:0]   ext_ll;
    logic [2*data_w-1:0]          sum;

    assign a_hi = src1[data_w:data_w/2];            // signed upper 17 bits
    assign a_lo = {1'b0, src1[data_w/2-1:0]};       // lower half, always positive
    assign b_hi = src2[data_w:data_w/2];
    assign b_lo = {1'b0, src2[data_w/2-1:0]};

    // stage 1: partial products
    always_ff @(posedge clk) begin
        if (rst) begin
            pp_hh <= '0;
            pp_hl <= '0;
            pp_lh <= '0;
            pp_ll <= '0;
        end else begin
            pp_hh <= a_hi * b_hi;
            pp_hl <= a_hi * b_lo;
            pp_lh <= a_lo * b_hi;
            pp_ll <= a_lo * b_lo;
        end
    end

    assign ext_hh = pp_hh;  // sign extend to product width
    assign ext_hl = pp_hl;
    assign ext_lh = pp_lh;
    assign ext_ll = pp_ll;

    assign sum = (ext_hh << data_w)
               + ((ext_hl + ext_lh) << (data_w / 2))
               + ext_ll;

    // stage 2: aligned sum
    always_ff @(posedge clk) begin
        if (rst) begin
            res <= '0;
        end else begin
            res <= sum;
        end
    end

endmodule

//--- exe_cfg_pkg.sv
package exe_cfg_pkg;

    // register stages inside mul_top, the select pipe in alu matches it
    localparam int mul_stages = 2;

    // radix-2 divider, one quotient bit per iteration
    localparam int div_iters = 32;
    localparam int div_cnt_w = 6;  // wide enough to count div_iters

endpackage

//--- alu_op_pkg.sv
package alu_op_pkg;

    localparam int data_w  = 32;  // operand and result width
    localparam int shamt_w = 5;   // shift amount taken from src2 low bits

    // decoded operation code, one value per operation
    typedef enum logic [4:0] {
        op_add   = 5'd0,
        op_sub   = 5'd1,
        op_slt   = 5'd2,   // signed compare
        op_sltu  = 5'd3,   // unsigned compare
        op_and   = 5'd4,
        op_nor   = 5'd5,
        op_or    = 5'd6,
        op_xor   = 5'd7,
        op_sll   = 5'd8,
        op_srl   = 5'd9,
        op_sra   = 5'd10,
        op_lui   = 5'd11,  // src2 passed through
        op_mul   = 5'd12,  // low word of product
        op_mulh  = 5'd13,  // signed high word
        op_mulhu = 5'd14,  // unsigned high word
        op_div   = 5'd15,
        op_divu  = 5'd16,
        op_mod   = 5'd17,
        op_modu  = 5'd18
    } alu_op_e;

endpackage
